/* dv/imp_copy_tb.sv */
`default_nettype none

module imp_copy_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam imp_pkg::data_t KEY       = 32'h5a3c_96e1;   // source data pattern
  localparam int             NUM_TESTS = 20;
  localparam int             MAX_CYC   = NUM_TESTS * (36 * 4 + 20);

  // --------------------------------------------------------------------------
  // DUT signals and scoreboard state
  // --------------------------------------------------------------------------
  logic                clk = 1'b0;
  logic                arst_n_i;
  logic                start_i;
  imp_pkg::win_cfg_t   win_cfg_i;
  imp_pkg::place_cfg_t rd_place_i;
  imp_pkg::place_cfg_t wr_place_i;
  logic                rd_req_o;
  imp_pkg::addr_t      rd_addr_o;
  logic                rd_valid_i;
  imp_pkg::data_t      rd_data_i;
  logic                wr_en_o;
  imp_pkg::addr_t      wr_addr_o;
  imp_pkg::data_t      wr_data_o;
  logic                busy_o;
  logic                done_o;

  integer         seed = 32'hc19f95fe;
  string          test_name = "reset";
  imp_pkg::addr_t exp_addr_q [$];   // destination order
  imp_pkg::data_t exp_data_q [$];
  imp_pkg::addr_t exp_a;
  imp_pkg::data_t exp_d;
  int unsigned    exp_pixels;
  int unsigned    reads_seen;
  int unsigned    writes_seen;
  int             cyc = 0;
  int             start_cyc;        // cycle in which start_i is high
  int             last_wr_cyc;
  int             done_cyc;
  bit             done_seen;
  bit             done_prev   = 1'b0;
  bit             move_active = 1'b0;
  int             err_cnt     = 0;

  always #50 clk = ~clk;

  imp_copy_top dut0 (
    .clk        ( clk        ),
    .arst_n_i   ( arst_n_i   ),
    .start_i    ( start_i    ),
    .win_cfg_i  ( win_cfg_i  ),
    .rd_place_i ( rd_place_i ),
    .wr_place_i ( wr_place_i ),
    .rd_req_o   ( rd_req_o   ),
    .rd_addr_o  ( rd_addr_o  ),
    .rd_valid_i ( rd_valid_i ),
    .rd_data_i  ( rd_data_i  ),
    .wr_en_o    ( wr_en_o    ),
    .wr_addr_o  ( wr_addr_o  ),
    .wr_data_o  ( wr_data_o  ),
    .busy_o     ( busy_o     ),
    .done_o     ( done_o     )
  );

  imp_src_mem #(.KEY(KEY)) src_mem0 (
    .clk_i   ( clk        ),
    .req_i   ( rd_req_o   ),
    .addr_i  ( rd_addr_o  ),
    .valid_o ( rd_valid_i ),
    .data_o  ( rd_data_i  )
  );

  task automatic stop_run();
    err_cnt++;
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERROR %s: %s expected 'h%0h actual 'h%0h", test_name, what, exp, act);
    stop_run();
  endtask

  task automatic report_problem(input string what);
    $display("%s: %s", test_name, what);
    stop_run();
  endtask

  // pixel (x, y) of a window placed in a frame
  function automatic imp_pkg::addr_t pixel_addr(input imp_pkg::place_cfg_t p,
                                                input int unsigned x, input int unsigned y);
    return p.baddr + (imp_pkg::addr_t'(p.coor_miny) + y) * p.adr_pitch
         + imp_pkg::addr_t'(p.coor_minx) + x;
  endfunction

  task automatic rand_win(output imp_pkg::win_cfg_t w);
    w.hsize = imp_pkg::size_t'($unsigned($random(seed)) % 32'd7);   // 0 to 6
    w.vsize = imp_pkg::size_t'($unsigned($random(seed)) % 32'd7);
  endtask

  task automatic rand_place(output imp_pkg::place_cfg_t p);
    p.baddr     = imp_pkg::addr_t'($random(seed)) & 32'h00ff_fff0;
    p.adr_pitch = 32'd8 + ($unsigned($random(seed)) % 32'd120);
    p.coor_minx = imp_pkg::coor_t'($random(seed));
    p.coor_miny = imp_pkg::coor_t'($random(seed));
  endtask

  // --------------------------------------------------------------------------
  // one move with prediction, start, optional start while busy and wait for done
  // --------------------------------------------------------------------------
  task automatic run_move(input string name, input imp_pkg::win_cfg_t win,
                          input imp_pkg::place_cfg_t src, input imp_pkg::place_cfg_t dst,
                          input bit poke);
    int unsigned         hs;
    int unsigned         vs;
    imp_pkg::win_cfg_t   junk_win;
    imp_pkg::place_cfg_t junk_place;
    hs        = 32'(win.hsize);
    vs        = 32'(win.vsize);
    test_name = name;
    for (int unsigned y = 0; y < vs; y++) begin      // row by row
      for (int unsigned x = 0; x < hs; x++) begin
        exp_addr_q.push_back(pixel_addr(dst, x, y));
        exp_data_q.push_back(pixel_addr(src, x, y) ^ KEY);
      end
    end
    exp_pixels  = hs * vs;
    reads_seen  = 0;
    writes_seen = 0;
    done_seen   = 1'b0;
    start_cyc   = cyc;
    move_active = 1'b1;
    win_cfg_i   = win;
    rd_place_i  = src;
    wr_place_i  = dst;
    start_i     = 1'b1;
    @(posedge clk);
    #10;
    start_i = 1'b0;
    rand_win(junk_win);       // config must be latched by now
    rand_place(junk_place);
    win_cfg_i  = junk_win;
    rd_place_i = junk_place;
    wr_place_i = junk_place;
    if (poke) begin
      assert (busy_o) else report_problem("busy_o low in the cycle after start");
      win_cfg_i = '{hsize: 16'd6, vsize: 16'd6};
      start_i   = 1'b1;       // must be ignored
      @(posedge clk);
      #10;
      start_i = 1'b0;
    end
    while (!done_seen) begin
      @(posedge clk);
      #10;
    end
    assert (writes_seen == exp_pixels)
      else report_mismatch("write count", exp_pixels, writes_seen);
    assert (reads_seen == exp_pixels)
      else report_mismatch("read count", exp_pixels, reads_seen);
    if (exp_pixels == 0) begin
      assert (done_cyc == start_cyc + 2)
        else report_mismatch("done cycle", start_cyc + 2, done_cyc);
    end else begin
      assert (done_cyc == last_wr_cyc + 1)
        else report_mismatch("done cycle", last_wr_cyc + 1, done_cyc);
    end
    move_active = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // scoreboard sampled mid cycle
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (!arst_n_i) begin
      assert (!rd_req_o && !wr_en_o && !busy_o && !done_o)
        else report_problem("outputs not low during reset");
    end else begin
      if (rd_req_o) reads_seen++;
      if (wr_en_o) begin
        assert (exp_addr_q.size() > 0)
          else report_problem("write strobe with no pixel left to write");
        exp_a = exp_addr_q.pop_front();
        exp_d = exp_data_q.pop_front();
        assert (wr_addr_o == exp_a) else report_mismatch("wr_addr_o", exp_a, wr_addr_o);
        assert (wr_data_o == exp_d) else report_mismatch("wr_data_o", exp_d, wr_data_o);
        writes_seen++;
        last_wr_cyc = cyc;
      end
      if (done_o) begin
        assert (!busy_o) else report_problem("busy_o still high in the done cycle");
        assert (!done_prev) else report_problem("done_o longer than one cycle");
        done_seen = 1'b1;
        done_cyc  = cyc;
      end else if (move_active && (cyc > start_cyc)) begin
        assert (busy_o) else report_problem("busy_o low during move");
      end else begin
        // also the start cycle, right after the previous done
        assert (!rd_req_o && !wr_en_o && !busy_o)
          else report_problem("activity while idle");
      end
      done_prev = done_o;
    end
  end

  // cycle count and timeout
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYC) begin
      $display("run did not finish within %0d cycles", MAX_CYC);
      stop_run();
    end
  end

  initial begin
    imp_pkg::win_cfg_t   win;
    imp_pkg::place_cfg_t src;
    imp_pkg::place_cfg_t dst;
    bit                  poke;
    arst_n_i   = 1'b0;
    start_i    = 1'b0;
    win_cfg_i  = '0;
    rd_place_i = '0;
    wr_place_i = '0;
    repeat (4) @(posedge clk);
    #10;
    arst_n_i = 1'b1;
    @(posedge clk);
    #10;

    win = '{hsize: 16'd3, vsize: 16'd2};
    src = '{baddr: 32'h0000_1000, adr_pitch: 32'd64, coor_minx: 8'd5, coor_miny: 8'd2};
    dst = '{baddr: 32'h0004_0000, adr_pitch: 32'd32, coor_minx: 8'd1, coor_miny: 8'd7};
    run_move("fixed_3x2", win, src, dst, 1'b0);
    rand_place(src);
    rand_place(dst);
    run_move("zero_hsize", '{hsize: 16'd0, vsize: 16'd4}, src, dst, 1'b0);
    run_move("zero_vsize", '{hsize: 16'd5, vsize: 16'd0}, src, dst, 1'b0);
    run_move("start_while_busy", '{hsize: 16'd4, vsize: 16'd3}, src, dst, 1'b1);
    run_move("full_6x6", '{hsize: 16'd6, vsize: 16'd6}, dst, src, 1'b0);  // sides swapped
    for (int i = 5; i < NUM_TESTS; i++) begin
      rand_win(win);
      rand_place(src);
      rand_place(dst);
      poke = (win.hsize != '0) && (win.vsize != '0) && (($random(seed) & 1) != 0);
      run_move($sformatf("random_%0d", i), win, src, dst, poke);
    end

    @(posedge clk);
    #10;
    if (err_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "errors found");
    end
  end

endmodule

`default_nettype wire

/* dv/imp_src_mem.sv */
`default_nettype none

module imp_src_mem #(
  parameter logic [31:0] KEY = 32'h0    // xor pattern for the returned data
) (
  input  logic           clk_i,
  input  logic           req_i,
  input  imp_pkg::addr_t addr_i,
  output logic           valid_o,
  output imp_pkg::data_t data_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic           req_s  = 1'b0;    // request seen in the current cycle
  imp_pkg::addr_t addr_s = '0;

  // request sampled mid cycle
  always @(negedge clk_i) begin
    req_s  = req_i;
    addr_s = addr_i;
  end

  // answer driven 10 ns after the next edge
  initial begin
    valid_o = 1'b0;
    data_o  = '0;
    forever begin
      @(posedge clk_i);
      #10;
      valid_o = req_s;
      data_o  = addr_s ^ KEY;    // address xor key
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/imp_pkg.sv
logic/imp_rd_addr_gen.sv
logic/imp_line_fifo.sv
logic/imp_wr_addr_gen.sv
logic/imp_copy_top.sv
dv/imp_src_mem.sv
dv/imp_copy_tb.sv

/* logic/imp_copy_top.sv */
`default_nettype none

`include "imp_defs.svh"

module imp_copy_top (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  imp_pkg::win_cfg_t   win_cfg_i,
  input  imp_pkg::place_cfg_t rd_place_i,    // source frame placement
  input  imp_pkg::place_cfg_t wr_place_i,    // destination frame placement
  output logic                rd_req_o,
  output imp_pkg::addr_t      rd_addr_o,
  input  logic                rd_valid_i,    // one cycle after rd_req_o
  input  imp_pkg::data_t      rd_data_i,
  output logic                wr_en_o,
  output imp_pkg::addr_t      wr_addr_o,
  output imp_pkg::data_t      wr_data_o,
  output logic                busy_o,
  output logic                done_o
);

  // --------------------------------------------------------------------------
  // internal wires
  // --------------------------------------------------------------------------
  imp_pkg::size_t fifo_count;   // credit info for the read side
  logic           fifo_empty;
  logic           fifo_pop;
  imp_pkg::data_t fifo_pop_data;
  logic           wr_fin;       // write side finished

  // producer
  imp_rd_addr_gen u0_imp_rd_addr_gen (
    .clk          ( clk           ),
    .arst_n_i     ( arst_n_i      ),
    .start_i      ( start_i       ),
    .win_cfg_i    ( win_cfg_i     ),
    .place_i      ( rd_place_i    ),
    .fifo_count_i ( fifo_count    ),
    .rd_valid_i   ( rd_valid_i    ),
    .fin_i        ( wr_fin        ),
    .rd_req_o     ( rd_req_o      ),
    .rd_addr_o    ( rd_addr_o     ),
    .busy_o       ( busy_o        )
  );

  // read data goes straight into the buffer
  imp_line_fifo #(
    .DEPTH        ( `IMP_FIFO_DEPTH )
  ) u0_imp_line_fifo (
    .clk          ( clk           ),
    .arst_n_i     ( arst_n_i      ),
    .push_i       ( rd_valid_i    ),
    .push_data_i  ( rd_data_i     ),
    .pop_i        ( fifo_pop      ),
    .pop_data_o   ( fifo_pop_data ),
    .empty_o      ( fifo_empty    ),
    .count_o      ( fifo_count    )
  );

  // consumer
  imp_wr_addr_gen u0_imp_wr_addr_gen (
    .clk          ( clk           ),
    .arst_n_i     ( arst_n_i      ),
    .start_i      ( start_i       ),
    .win_cfg_i    ( win_cfg_i     ),
    .place_i      ( wr_place_i    ),
    .empty_i      ( fifo_empty    ),
    .pop_data_i   ( fifo_pop_data ),
    .pop_o        ( fifo_pop      ),
    .wr_en_o      ( wr_en_o       ),
    .wr_addr_o    ( wr_addr_o     ),
    .wr_data_o    ( wr_data_o     ),
    .fin_o        ( wr_fin        ),
    .done_o       ( done_o        )
  );

endmodule

`default_nettype wire

/* logic/imp_defs.svh */
`ifndef IMP_DEFS_SVH
`define IMP_DEFS_SVH

// --------------------------------------------------------------------------
// datapath widths of the image move
// --------------------------------------------------------------------------

`define IMP_DATA_W      32    // one pixel per word
`define IMP_ADDR_W      32    // word address on both sides

// window geometry
`define IMP_SIZE_W      16    // hsize / vsize and pixel counters
`define IMP_COOR_W      8     // minx / miny offsets

// --------------------------------------------------------------------------
// line buffer between read side and write side
// --------------------------------------------------------------------------

// credit limit seen by the read side
`define IMP_FIFO_DEPTH  4

`endif

/* logic/imp_line_fifo.sv */
`default_nettype none

`include "imp_defs.svh"

module imp_line_fifo #(
  parameter int DEPTH = `IMP_FIFO_DEPTH
) (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            push_i,
  input  imp_pkg::data_t  push_data_i,
  input  logic            pop_i,
  output imp_pkg::data_t  pop_data_o,
  output logic            empty_o,
  output imp_pkg::size_t  count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // --------------------------------------------------------------------------
  // storage and pointers
  // --------------------------------------------------------------------------
  imp_pkg::data_t   mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  imp_pkg::size_t   count_q;    // occupancy
  logic             full;

  assign full       = (count_q == imp_pkg::size_t'(DEPTH));
  assign empty_o    = (count_q == '0);
  assign count_o    = count_q;
  assign pop_data_o = mem_q[rd_ptr_q];   // head word valid when not empty

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // pointers wrap at DEPTH
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // both or neither
      endcase
    end
  end

  // push is throttled by read credit and pop by empty
  a_no_overflow : assert property (@(posedge clk) disable iff (!arst_n_i)
    push_i |-> !full);
  a_no_underflow : assert property (@(posedge clk) disable iff (!arst_n_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* logic/imp_pkg.sv */
`default_nettype none

`include "imp_defs.svh"

package imp_pkg;

  // --------------------------------------------------------------------------
  // widths with a meaning
  // --------------------------------------------------------------------------
  typedef logic [`IMP_DATA_W-1:0] data_t;  // pixel word
  typedef logic [`IMP_ADDR_W-1:0] addr_t;  // word address
  typedef logic [`IMP_SIZE_W-1:0] size_t;  // window dimension or counter
  typedef logic [`IMP_COOR_W-1:0] coor_t;  // min coordinate

  // window shared by read and write side
  typedef struct packed {
    size_t hsize;    // pixels per line
    size_t vsize;    // lines
  } win_cfg_t;

  // placement of the window inside one frame
  typedef struct packed {
    addr_t baddr;      // frame base
    addr_t adr_pitch;  // words per frame line
    coor_t coor_minx;  // window left edge
    coor_t coor_miny;  // window top edge
  } place_cfg_t;

  // read side FSM
  typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_DRAIN} rd_state_e;

  // write side FSM
  typedef enum logic [1:0] {WR_IDLE, WR_MOVE, WR_DONE} wr_state_e;

endpackage

`default_nettype wire

/* logic/imp_rd_addr_gen.sv */
`default_nettype none

`include "imp_defs.svh"

module imp_rd_addr_gen (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  imp_pkg::win_cfg_t   win_cfg_i,
  input  imp_pkg::place_cfg_t place_i,
  input  imp_pkg::size_t      fifo_count_i,   // fill level of the line buffer
  input  logic                rd_valid_i,     // read data returning this cycle
  input  logic                fin_i,          // write side finished
  output logic                rd_req_o,
  output imp_pkg::addr_t      rd_addr_o,
  output logic                busy_o
);

  // --------------------------------------------------------------------------
  // state, walk and credit registers
  // --------------------------------------------------------------------------
  imp_pkg::rd_state_e state_q;
  imp_pkg::win_cfg_t  win_q;        // window latched on start
  imp_pkg::addr_t     pitch_q;      // source line pitch
  imp_pkg::addr_t     row_base_q;   // address of pixel (0, y_q)
  imp_pkg::size_t     x_q;
  imp_pkg::size_t     y_q;
  imp_pkg::size_t     inflight_q;   // issued reads not back yet

  logic start_ok;
  logic win_empty;
  logic credit_ok;
  logic last_x;
  logic last_y;

  // a new move may load in the done cycle as well
  assign start_ok  = start_i && ((state_q == imp_pkg::RD_IDLE) || fin_i);
  assign win_empty = (win_cfg_i.hsize == '0) || (win_cfg_i.vsize == '0);

  // buffered words plus words on the way must leave room for one more
  assign credit_ok = (fifo_count_i + inflight_q) < imp_pkg::size_t'(`IMP_FIFO_DEPTH);

  assign last_x    = (x_q == win_q.hsize - 1'b1);
  assign last_y    = (y_q == win_q.vsize - 1'b1);

  assign rd_req_o  = (state_q == imp_pkg::RD_ISSUE) && credit_ok;
  assign rd_addr_o = row_base_q + imp_pkg::addr_t'(x_q);   // row base plus column
  assign busy_o    = (state_q != imp_pkg::RD_IDLE) && !fin_i;  // falls with done

  // --------------------------------------------------------------------------
  // FSM and pixel walk
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= imp_pkg::RD_IDLE;
      x_q     <= '0;
      y_q     <= '0;
    end else if (start_ok) begin
      state_q <= win_empty ? imp_pkg::RD_DRAIN : imp_pkg::RD_ISSUE;  // empty window reads nothing
      x_q     <= '0;
      y_q     <= '0;
    end else begin
      case (state_q)
        imp_pkg::RD_ISSUE: begin
          if (rd_req_o) begin
            if (last_x) begin
              x_q <= '0;
              if (last_y) begin
                state_q <= imp_pkg::RD_DRAIN;   // all reads out
              end else begin
                y_q <= y_q + 1'b1;
              end
            end else begin
              x_q <= x_q + 1'b1;
            end
          end
        end
        imp_pkg::RD_DRAIN: begin
          if (fin_i) begin
            state_q <= imp_pkg::RD_IDLE;        // last write is out
          end
        end
        default: state_q <= state_q;
      endcase
    end
  end

  // config latch and row base
  always_ff @(posedge clk) begin
    if (start_ok) begin
      win_q      <= win_cfg_i;
      pitch_q    <= place_i.adr_pitch;
      row_base_q <= place_i.baddr
                  + imp_pkg::addr_t'(place_i.coor_miny) * place_i.adr_pitch
                  + imp_pkg::addr_t'(place_i.coor_minx);
    end else if (rd_req_o && last_x && !last_y) begin
      row_base_q <= row_base_q + pitch_q;       // next line
    end
  end

  // reads in flight until memory answers
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inflight_q <= '0;
    end else begin
      case ({rd_req_o, rd_valid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // buffered words plus the word now returning leave room for the request
  a_rd_credit : assert property (@(posedge clk) disable iff (!arst_n_i)
    rd_req_o |-> (fifo_count_i + imp_pkg::size_t'(rd_valid_i))
                 < imp_pkg::size_t'(`IMP_FIFO_DEPTH));

endmodule

`default_nettype wire

/* logic/imp_wr_addr_gen.sv */
`default_nettype none

module imp_wr_addr_gen (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  imp_pkg::win_cfg_t   win_cfg_i,
  input  imp_pkg::place_cfg_t place_i,
  input  logic                empty_i,
  input  imp_pkg::data_t      pop_data_i,
  output logic                pop_o,
  output logic                wr_en_o,
  output imp_pkg::addr_t      wr_addr_o,
  output imp_pkg::data_t      wr_data_o,
  output logic                fin_o,        // tells read side to go idle
  output logic                done_o
);

  // --------------------------------------------------------------------------
  // state and destination walk
  // --------------------------------------------------------------------------
  imp_pkg::wr_state_e state_q;
  imp_pkg::win_cfg_t  win_q;
  imp_pkg::addr_t     pitch_q;       // destination line pitch
  imp_pkg::addr_t     row_base_q;    // address of pixel (0, y_q)
  imp_pkg::size_t     x_q;
  imp_pkg::size_t     y_q;
  logic               all_popped_q;  // last pixel taken from the buffer

  logic start_ok;
  logic last_x;
  logic last_y;

  assign start_ok = start_i && ((state_q == imp_pkg::WR_IDLE) || (state_q == imp_pkg::WR_DONE));
  assign last_x   = (x_q == win_q.hsize - 1'b1);
  assign last_y   = (y_q == win_q.vsize - 1'b1);

  assign pop_o    = (state_q == imp_pkg::WR_MOVE) && !all_popped_q && !empty_i;
  assign done_o   = (state_q == imp_pkg::WR_DONE);  // one cycle, after last write
  assign fin_o    = done_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= imp_pkg::WR_IDLE;
      x_q          <= '0;
      y_q          <= '0;
      all_popped_q <= 1'b0;
    end else if (start_ok) begin
      state_q      <= imp_pkg::WR_MOVE;
      x_q          <= '0;
      y_q          <= '0;
      all_popped_q <= (win_cfg_i.hsize == '0) || (win_cfg_i.vsize == '0);
    end else begin
      case (state_q)
        imp_pkg::WR_MOVE: begin
          if (all_popped_q) begin
            state_q <= imp_pkg::WR_DONE;   // last write is out this cycle
          end else if (pop_o) begin
            if (last_x) begin
              x_q <= '0;
              if (last_y) begin
                all_popped_q <= 1'b1;
              end else begin
                y_q <= y_q + 1'b1;
              end
            end else begin
              x_q <= x_q + 1'b1;
            end
          end
        end
        imp_pkg::WR_DONE: state_q <= imp_pkg::WR_IDLE;
        default:          state_q <= state_q;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // config latch and write payload
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (start_ok) begin
      win_q      <= win_cfg_i;
      pitch_q    <= place_i.adr_pitch;
      row_base_q <= place_i.baddr
                  + imp_pkg::addr_t'(place_i.coor_miny) * place_i.adr_pitch
                  + imp_pkg::addr_t'(place_i.coor_minx);
    end else if (pop_o && last_x && !last_y) begin
      row_base_q <= row_base_q + pitch_q;
    end
    if (pop_o) begin
      wr_addr_o <= row_base_q + imp_pkg::addr_t'(x_q);   // address of popped pixel
      wr_data_o <= pop_data_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_en_o <= 1'b0;
    end else begin
      wr_en_o <= pop_o;   // write one cycle after pop
    end
  end

  // DONE is only entered the cycle after the final write strobe
  a_wr_in_move : assert property (@(posedge clk) disable iff (!arst_n_i)
    wr_en_o |-> (state_q == imp_pkg::WR_MOVE));

endmodule

`default_nettype wire

/* run_verilator.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module imp_copy_tb -f flist.f

./obj_dir/Vimp_copy_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
grep -q "TEST PASSED" sim.log
echo "simulation passed"
